/* Makefile */
sim:
	verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f -Mdir obj_dir
	./obj_dir/Vtb_rv_core

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_fn_e alu_fn,
    output logic [31:0]     y,
    output logic            eq
);

    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Only the low 5 bits shift

    always_comb begin
        unique case (alu_fn)
            ADD:     y = a + b;
            SUB:     y = a - b;
            AND:     y = a & b;
            OR:      y = a | b;
            XOR:     y = a ^ b;
            SLT:     y = {31'b0, $signed(a) < $signed(b)};
            SLL:     y = a << shamt;
            SRL:     y = a >> shamt;
            SRA:     y = $signed(a) >>> shamt;
            default: y = '0;
        endcase
    end

    // With SUB this flags equal operands for BEQ
    assign eq = (y == 32'd0);

endmodule

`default_nettype wire

/* logic/alu_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
    input  rv_pkg::alu_sel_e alu_sel,
    input  logic [2:0]       funct3,
    input  logic             funct7_5,
    input  logic             op_5,
    output rv_pkg::alu_fn_e  alu_fn
);

    import rv_pkg::*;

    always_comb begin
        alu_fn = ADD;

        unique case (alu_sel)
            ALU_SEL_ADD: alu_fn = ADD;
            ALU_SEL_SUB: alu_fn = SUB;
            ALU_SEL_FUNCT: begin
                unique case (funct3)
                    3'b000:  alu_fn = (op_5 && funct7_5) ? SUB : ADD; // ADDI has no SUB form
                    3'b001:  alu_fn = SLL;
                    3'b010:  alu_fn = SLT;
                    3'b100:  alu_fn = XOR;
                    3'b101:  alu_fn = funct7_5 ? SRA : SRL; // Same bit in R and I forms
                    3'b110:  alu_fn = OR;
                    3'b111:  alu_fn = AND;
                    default: alu_fn = ADD; // SLTU not supported
                endcase
            end
            default: alu_fn = ADD;
        endcase
    end

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  logic [31:0]      instr,
    input  rv_pkg::imm_sel_e imm_sel,
    output logic [31:0]      imm
);

    import rv_pkg::*;

    always_comb begin
        unique case (imm_sel)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                // Halfword offset, bit 0 implied
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/main_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module main_decoder (
    input  logic [6:0]    opcode,
    input  logic          eq,
    output rv_pkg::ctrl_t ctrl
);

    import rv_pkg::*;

    always_comb begin
        ctrl = '0; // Unknown opcodes fall through as a no-op

        unique case (opcode)
            OP: begin
                ctrl.result_sel = RES_ALU;
                ctrl.alu_src    = 1'b0;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_sel    = ALU_SEL_FUNCT;
            end

            LOAD: begin
                ctrl.result_sel = RES_MEM; // Data comes back from memory
                ctrl.alu_src    = 1'b1;
                ctrl.imm_sel    = IMM_I;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_sel    = ALU_SEL_ADD; // Base plus offset
            end

            OP_IMM: begin
                ctrl.result_sel = RES_ALU;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_sel    = IMM_I;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_sel    = ALU_SEL_FUNCT;
            end

            STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_sel   = IMM_S;
                ctrl.alu_sel   = ALU_SEL_ADD;
            end

            BRANCH: begin
                ctrl.pc_src  = eq; // Only BEQ is supported
                ctrl.alu_src = 1'b0;
                ctrl.imm_sel = IMM_B;
                ctrl.alu_sel = ALU_SEL_SUB;
            end

            JALR: begin
                ctrl.pc_src     = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.result_sel = RES_PC4;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_sel    = IMM_I;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_sel    = ALU_SEL_ADD; // rs1 + imm
            end

            JAL: begin
                ctrl.pc_src     = 1'b1;
                ctrl.result_sel = RES_PC4;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_sel    = IMM_J;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_sel    = ALU_SEL_ADD;
            end

            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wd; // x0 is never written
        end
    end

    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_write,
    input  logic [31:0] dmem_rdata,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    import rv_pkg::*;

    ctrl_t       ctrl;
    alu_fn_e     alu_fn;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic        eq;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;
    logic [31:0] result;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    main_decoder u_main_decoder (.opcode(instr[6:0]), .eq(eq), .ctrl(ctrl));

    alu_decoder u_alu_decoder (
        .alu_sel (ctrl.alu_sel),
        .funct3  (instr[14:12]),
        .funct7_5(instr[30]),
        .op_5    (instr[5]),    // Set for R-type only
        .alu_fn  (alu_fn)
    );

    imm_gen u_imm_gen (.instr(instr), .imm_sel(ctrl.imm_sel), .imm(imm));

    reg_file u_reg_file (
        .clk  (clk),
        .rst_n(rst_n),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .we   (ctrl.reg_write),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    assign alu_b = ctrl.alu_src ? imm : rd2;

    alu u_alu (.a(rd1), .b(alu_b), .alu_fn(alu_fn), .y(alu_y), .eq(eq));

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        unique case (ctrl.result_sel)
            RES_MEM: result = dmem_rdata;
            RES_PC4: result = pc_plus4; // Link address
            default: result = alu_y;
        endcase
    end

    // JALR target drops bit 0, JAL and taken BEQ are pc relative
    assign pc_next = ctrl.jalr   ? {alu_y[31:1], 1'b0} :
                     ctrl.pc_src ? pc + imm : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    assign dmem_addr  = alu_y;
    assign dmem_wdata = rd2;
    assign dmem_write = rst_n && ctrl.mem_write; // Quiet while in reset

    assign wb_valid = rst_n && ctrl.reg_write && (rd != 5'd0);
    assign wb_rd    = rd;
    assign wb_data  = result;

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_SEL_ADD   = 3'd0, // Address and link arithmetic
        ALU_SEL_SUB   = 3'd1, // Branch compare
        ALU_SEL_FUNCT = 3'd2  // Let funct3/funct7 decide
    } alu_sel_e;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5, // Signed compare
        SLL = 4'd6,
        SRL = 4'd7,
        SRA = 4'd8
    } alu_fn_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3
    } imm_sel_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2 // Link value for jumps
    } result_sel_e;

    typedef struct packed {
        logic        pc_src;     // Take a jump or branch target
        logic        jalr;       // Target from ALU result
        result_sel_e result_sel;
        logic        mem_write;
        logic        alu_src;    // Operand B is the immediate
        imm_sel_e    imm_sel;
        logic        reg_write;
        alu_sel_e    alu_sel;
    } ctrl_t;

endpackage

`default_nettype wire

/* rv_core.f */
logic/rv_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/imm_gen.sv
logic/alu.sv
logic/reg_file.sv
logic/rv_core.sv
test/rv_core_chk.sv
test/tb_rv_core.sv

/* test/rv_core_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_chk (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] pc,
    input logic        dmem_write,
    input logic        wb_valid,
    input logic [4:0]  wb_rd
);

    // Memory and trace see nothing while in reset
    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_write)
        else $error("dmem_write high while rst_n is low");
    no_trace_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else $error("wb_valid high while rst_n is low");

    pc_aligned: assert property (@(posedge clk) rst_n |-> pc[1:0] == 2'b00)
        else $error("pc is not word aligned");
    no_x0_trace: assert property (@(posedge clk) wb_valid |-> wb_rd != 5'd0)
        else $error("trace reports a write to x0");

endmodule

`default_nettype wire

/* test/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    import rv_pkg::*;

    localparam int clk_period = 4;
    localparam int n_instr    = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_write;
    logic [31:0] dmem_rdata;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [64];
    logic [31:0] dmem [64];  // Memory seen by the DUT
    logic [31:0] mdmem [64]; // Model copy
    logic [31:0] mregs [32];
    logic [31:0] mpc;
    logic [31:0] lfsr;

    rv_core #(.reset_pc(32'h100)) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .instr     (instr),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_write(dmem_write),
        .dmem_rdata(dmem_rdata),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    bind rv_core rv_core_chk chk (
        .clk(clk), .rst_n(rst_n), .pc(pc),
        .dmem_write(dmem_write), .wb_valid(wb_valid), .wb_rd(wb_rd)
    );

    always #(clk_period / 2) clk = ~clk;

    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_write) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [3:0]  r;
        logic [7:0]  v8;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        kind = 4'(rand_bits(4));
        rd   = 5'(rand_bits(3)); // x0..x7 only
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        f3   = 3'(rand_bits(3));
        alt  = rand_bits(1) != 32'd0;
        r    = 4'(rand_bits(4));
        v8   = 8'(rand_bits(8));
        if (f3 == 3'b011) f3 = 3'b000; // No SLTU
        if (r == 4'd0) r = 4'd1; // Avoid jumping onto itself
        boff = {{7{r[3]}}, r, 2'b00};
        joff = {{15{r[3]}}, r, 2'b00};
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3:
                return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, OP};
            4'd4, 4'd5, 4'd6: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, alt && f3 == 3'b101, 5'b0, v8[4:0]}; // Shift amount
                end else begin
                    imm = {{4{v8[7]}}, v8};
                end
                return {imm, rs1, f3, rd, OP_IMM};
            end
            4'd7, 4'd8:
                return {4'b0, v8[5:0], 2'b00, 5'd0, 3'b010, rd, LOAD};
            4'd9, 4'd10:
                return {4'b0, v8[5:3], rs2, 5'd0, 3'b010, v8[2:0], 2'b00, STORE};
            4'd11, 4'd12:
                return {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11], BRANCH};
            4'd13:
                return {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
            4'd14:
                return {3'b000, v8[5:0], 2'b00, alt, 5'd0, 3'b000, rd, JALR}; // Odd imm
            default:
                return {25'(rand_bits(25)), alt ? 7'b0001011 : 7'b0110111};
        endcase
    endfunction

    // Result of an RV32I ALU op per funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Executes the current instruction in the model and compares the DUT
    task automatic step_model();
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] npc;
        logic        wr;
        logic        st;
        rd    = instr[11:7];
        a     = mregs[instr[19:15]];
        b     = mregs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        wr    = 1'b0;
        st    = 1'b0;
        res   = '0;
        addr  = '0;
        npc   = mpc + 32'd4;
        case (instr[6:0])
            OP: begin
                wr  = 1'b1;
                res = alu_ref(instr[14:12], instr[30], a, b);
            end
            OP_IMM: begin
                wr  = 1'b1;
                res = alu_ref(instr[14:12], instr[30] && instr[14:12] == 3'b101, a, imm_i);
            end
            LOAD: begin
                wr   = 1'b1;
                addr = a + imm_i;
                res  = mdmem[addr[7:2]];
            end
            STORE: begin
                st   = 1'b1;
                addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                if (a == b) begin
                    npc = mpc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
                end
            end
            JAL: begin
                wr  = 1'b1;
                res = mpc + 32'd4;
                npc = mpc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
            end
            JALR: begin
                wr  = 1'b1;
                res = mpc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            default: ;
        endcase
        wr = wr && (rd != 5'd0); // x0 writes are dropped
        check("wb_valid", 32'(wb_valid), 32'(wr));
        if (wr) begin
            check("wb_rd", 32'(wb_rd), 32'(rd));
            check("wb_data", wb_data, res);
            mregs[rd] = res;
        end
        check("dmem_write", 32'(dmem_write), 32'(st));
        if (st) begin
            check("dmem_addr", dmem_addr, addr);
            check("dmem_wdata", dmem_wdata, b);
            mdmem[addr[7:2]] = b;
        end
        mpc = npc;
    endtask

    initial begin
        rst_n = 1'b0;
        instr = 32'h0;
        lfsr  = 32'h5e2a;
        mpc   = 32'h100;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i]  = {16'hd00d, 8'(i), 8'(~i)};
            mdmem[i] = {16'hd00d, 8'(i), 8'(~i)};
            prog[i]  = gen_instr();
        end
        // Random instructions in reset must not leak a store or a trace
        for (int i = 0; i < 4; i++) begin
            #1;
            check("dmem_write", 32'(dmem_write), 32'd0);
            check("wb_valid", 32'(wb_valid), 32'd0);
            @(negedge clk);
            instr = prog[i];
        end
        rst_n = 1'b1;
        for (int n = 0; n < n_instr; n++) begin
            check("pc", pc, mpc);
            instr = prog[mpc[7:2]];
            prog[mpc[7:2]] = gen_instr(); // Fresh code on the next visit
            #1;
            step_model();
            @(negedge clk);
        end
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #((n_instr + 20) * clk_period);
        $display("Watchdog expired before all instructions were checked");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire
